// ==== lsu_apb_master.sv ====
`timescale 1ns/10ps

module lsu_apb_master (
    input  logic                       clk_i,
    input  logic                       arst_n_i,
    input  logic                       start_i,
    input  logic                       write_i,
    input  logic [lsu_pkg::ADDR_W-1:0] addr_i,
    input  logic [lsu_pkg::WORD_W-1:0] wdata_i,
    input  logic [3:0]                 strb_i,
    input  logic [lsu_pkg::WORD_W-1:0] prdata_i,
    input  logic                       pready_i,
    output logic                       done_o,
    output logic [lsu_pkg::WORD_W-1:0] rdata_o,
    output logic [lsu_pkg::ADDR_W-1:0] paddr_o,
    output logic                       psel_o,
    output logic                       penable_o,
    output logic                       pwrite_o,
    output logic [lsu_pkg::WORD_W-1:0] pwdata_o,
    output logic [3:0]                 pstrb_o
);

    logic launch;
    logic xfer_end;

    assign launch   = start_i && !psel_o;
    assign xfer_end = psel_o && penable_o && pready_i;

    // psel and penable double as the transfer phase
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            psel_o    <= 1'b0;
            penable_o <= 1'b0;
            pwrite_o  <= 1'b0;
            done_o    <= 1'b0;
        end else begin
            done_o <= xfer_end;
            if (launch) begin
                psel_o   <= 1'b1;
                pwrite_o <= write_i;
            end else if (psel_o && !penable_o) begin
                penable_o <= 1'b1;
            end else if (xfer_end) begin
                psel_o    <= 1'b0;
                penable_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (launch) begin
            paddr_o  <= addr_i;
            pwdata_o <= wdata_i;
            // reads drive no byte strobes
            pstrb_o  <= write_i ? strb_i : 4'b0000;
        end
        if (xfer_end) begin
            rdata_o <= prdata_i;
        end
    end

    a_apb_stable: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        penable_o && !pready_i |=> $stable(paddr_o) && $stable(pwdata_o)
    );

endmodule

// ==== lsu_ctrl.sv ====
`timescale 1ns/10ps

module lsu_ctrl (
    input  logic clk_i,
    input  logic arst_n_i,
    input  logic req_store_i,
    input  logic req_load_i,
    input  logic fence_i,
    input  logic sb_hit_i,
    input  logic sb_cover_i,
    input  logic sb_full_i,
    input  logic sb_empty_i,
    input  logic apb_done_i,
    output logic stall_o,
    output logic sb_alloc_o,
    output logic sb_drain_o,
    output logic apb_start_o,
    output logic apb_write_o,
    output logic rd_addr_sel_o,
    output logic load_valid_o,
    output logic load_src_o
);

    lsu_pkg::lsu_state_e state_q;
    lsu_pkg::lsu_state_e state_d;
    logic                store_fits;
    logic                in_idle;

    // a store merges into its word or takes a free slot
    assign store_fits = sb_hit_i || !sb_full_i;
    assign in_idle    = (state_q == lsu_pkg::IDLE);

    always_comb begin
        state_d       = state_q;
        sb_alloc_o    = 1'b0;
        sb_drain_o    = 1'b0;
        apb_start_o   = 1'b0;
        apb_write_o   = 1'b0;
        rd_addr_sel_o = 1'b0;
        case (state_q)
            lsu_pkg::IDLE: begin
                if (req_store_i && store_fits) begin
                    sb_alloc_o = 1'b1;
                end else if (req_load_i && sb_hit_i && sb_cover_i) begin
                    state_d = lsu_pkg::FWD;
                end else if (req_load_i && !sb_hit_i) begin
                    state_d = lsu_pkg::RD_SETUP;
                end else if (!sb_empty_i) begin
                    // full on a store miss, partial hit, fence or nothing to do
                    apb_start_o = 1'b1;
                    apb_write_o = 1'b1;
                    state_d     = lsu_pkg::DRAIN;
                end
            end
            lsu_pkg::DRAIN: begin
                if (apb_done_i) begin
                    sb_drain_o = 1'b1;
                    state_d    = lsu_pkg::IDLE;
                end
            end
            lsu_pkg::RD_SETUP: begin
                apb_start_o   = 1'b1;
                rd_addr_sel_o = 1'b1;
                state_d       = lsu_pkg::RD_WAIT;
            end
            lsu_pkg::RD_WAIT: begin
                if (apb_done_i) begin
                    state_d = lsu_pkg::IDLE;
                end
            end
            default: begin
                state_d = lsu_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= lsu_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // stores and fences only complete from IDLE
    assign stall_o = (req_store_i && !(in_idle && store_fits)) ||
                     (fence_i && !(in_idle && sb_empty_i));

    assign load_src_o   = (state_q == lsu_pkg::FWD);
    assign load_valid_o = load_src_o || (state_q == lsu_pkg::RD_WAIT && apb_done_i);

    a_load_valid_pulse: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        load_valid_o |=> !load_valid_o
    );

endmodule

// ==== lsu_load_align.sv ====
`timescale 1ns/10ps

module lsu_load_align (
    input  logic [lsu_pkg::WORD_W-1:0] word_i,
    input  logic [1:0]                 addr_lo_i,
    input  lsu_pkg::memop_size_e       size_i,
    output logic [lsu_pkg::WORD_W-1:0] data_o
);

    logic [lsu_pkg::WORD_W-1:0] shifted;

    // move the addressed lane down to bit 0
    assign shifted = word_i >> {addr_lo_i, 3'b000};

    // zero-fill above the loaded bytes
    always_comb begin
        case (size_i)
            lsu_pkg::BYTE: data_o = {24'h0, shifted[7:0]};
            lsu_pkg::HALF: data_o = {16'h0, shifted[15:0]};
            default:       data_o = word_i;
        endcase
    end

endmodule

// ==== lsu_pkg.sv ====
package lsu_pkg;

    // fixed datapath widths, the lane logic assumes four bytes per word
    localparam int ADDR_W = 32;
    localparam int WORD_W = 32;

    // access size of a load or store
    typedef enum logic [1:0] {
        BYTE = 2'd0,
        HALF = 2'd1,
        WORD = 2'd2
    } memop_size_e;

    // load/store controller states
    typedef enum logic [2:0] {
        IDLE     = 3'd0,
        DRAIN    = 3'd1,
        RD_SETUP = 3'd2,
        RD_WAIT  = 3'd3,
        FWD      = 3'd4
    } lsu_state_e;

endpackage

// ==== lsu_store_buffer.sv ====
`timescale 1ns/10ps

module lsu_store_buffer #(
    parameter int SB_DEPTH = 2
) (
    input  logic                       clk_i,
    input  logic                       arst_n_i,
    input  logic                       alloc_i,
    input  logic [lsu_pkg::ADDR_W-1:0] addr_i,
    input  logic [lsu_pkg::WORD_W-1:0] wdata_i,
    input  lsu_pkg::memop_size_e       size_i,
    input  logic                       drain_i,
    output logic                       hit_o,
    output logic                       cover_o,
    output logic                       full_o,
    output logic                       empty_o,
    output logic [lsu_pkg::WORD_W-1:0] fwd_word_o,
    output logic [lsu_pkg::ADDR_W-1:0] head_addr_o,
    output logic [lsu_pkg::WORD_W-1:0] head_data_o,
    output logic [3:0]                 head_strb_o
);

    localparam int IDX_W = $clog2(SB_DEPTH);
    localparam int WADDR_W = lsu_pkg::ADDR_W - 2;

    // entry storage
    logic [SB_DEPTH-1:0]  valid_q;
    logic [WADDR_W-1:0]   waddr_q [SB_DEPTH];
    logic [3:0][7:0]      data_q [SB_DEPTH];
    logic [3:0]           mask_q [SB_DEPTH];

    // head is where the next new word goes, tail is the oldest entry
    logic [IDX_W-1:0]     head_q;
    logic [IDX_W-1:0]     tail_q;

    logic                 hit_any;
    logic [IDX_W-1:0]     hit_idx;
    logic [3:0]           acc_mask;
    logic [3:0][7:0]      lane_data;
    logic [IDX_W-1:0]     wr_idx;

    // byte lanes touched by the access
    always_comb begin
        case (size_i)
            lsu_pkg::BYTE: acc_mask = 4'b0001 << addr_i[1:0];
            lsu_pkg::HALF: acc_mask = 4'b0011 << {addr_i[1], 1'b0};
            default:       acc_mask = 4'b1111;
        endcase
    end

    // replicate the store data so every lane carries its byte
    always_comb begin
        case (size_i)
            lsu_pkg::BYTE: lane_data = {4{wdata_i[7:0]}};
            lsu_pkg::HALF: lane_data = {2{wdata_i[15:0]}};
            default:       lane_data = wdata_i;
        endcase
    end

    // word match, merging keeps at most one entry per word
    always_comb begin
        hit_any = 1'b0;
        hit_idx = '0;
        for (int i = 0; i < SB_DEPTH; i++) begin
            if (valid_q[i] && waddr_q[i] == addr_i[lsu_pkg::ADDR_W-1:2]) begin
                hit_any = 1'b1;
                hit_idx = IDX_W'(i);
            end
        end
    end

    assign hit_o   = hit_any;
    assign cover_o = hit_any && ((mask_q[hit_idx] & acc_mask) == acc_mask);

    // entries are filled in order, so the head slot tells full and the tail slot empty
    assign full_o  = valid_q[head_q];
    assign empty_o = !valid_q[tail_q];

    assign head_addr_o = {waddr_q[tail_q], 2'b00};
    assign head_data_o = data_q[tail_q];
    assign head_strb_o = mask_q[tail_q];

    assign wr_idx = hit_any ? hit_idx : head_q;

    // merge into the matching entry or open a new one
    always_ff @(posedge clk_i) begin
        if (alloc_i) begin
            waddr_q[wr_idx] <= addr_i[lsu_pkg::ADDR_W-1:2];
            mask_q[wr_idx]  <= hit_any ? (mask_q[wr_idx] | acc_mask) : acc_mask;
            for (int b = 0; b < 4; b++) begin
                if (acc_mask[b]) begin
                    data_q[wr_idx][b] <= lane_data[b];
                end
            end
        end
    end

    // forwarded word is registered for the cycle after the load request
    always_ff @(posedge clk_i) begin
        fwd_word_o <= data_q[hit_idx];
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= '0;
            head_q  <= '0;
            tail_q  <= '0;
        end else begin
            if (alloc_i && !hit_any) begin
                valid_q[head_q] <= 1'b1;
                head_q          <= head_q + IDX_W'(1);
            end
            if (drain_i) begin
                valid_q[tail_q] <= 1'b0;
                tail_q          <= tail_q + IDX_W'(1);
            end
        end
    end

    // the controller must drain before it allocates a new word into a full buffer
    a_no_alloc_full: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        alloc_i && !hit_o |-> !full_o
    );

    // drain requests only come while an entry is waiting
    a_no_drain_empty: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        drain_i |-> !empty_o
    );

endmodule

// ==== lsu_top.sv ====
`timescale 1ns/10ps

module lsu_top #(
    parameter int SB_DEPTH = 2
) (
    input  logic                       clk_i,
    input  logic                       arst_n_i,
    input  logic                       req_store_i,
    input  logic                       req_load_i,
    input  logic                       fence_i,
    input  logic [lsu_pkg::ADDR_W-1:0] addr_i,
    input  logic [lsu_pkg::WORD_W-1:0] wdata_i,
    input  lsu_pkg::memop_size_e       size_i,
    input  logic [lsu_pkg::WORD_W-1:0] prdata_i,
    input  logic                       pready_i,
    output logic                       stall_o,
    output logic                       load_valid_o,
    output logic [lsu_pkg::WORD_W-1:0] load_data_o,
    output logic [lsu_pkg::ADDR_W-1:0] paddr_o,
    output logic                       psel_o,
    output logic                       penable_o,
    output logic                       pwrite_o,
    output logic [lsu_pkg::WORD_W-1:0] pwdata_o,
    output logic [3:0]                 pstrb_o
);

    logic                       sb_alloc;
    logic                       sb_drain;
    logic                       sb_hit;
    logic                       sb_cover;
    logic                       sb_full;
    logic                       sb_empty;
    logic                       apb_start;
    logic                       apb_write;
    logic                       apb_done;
    logic                       rd_addr_sel;
    logic                       load_src;
    logic [lsu_pkg::WORD_W-1:0] fwd_word;
    logic [lsu_pkg::ADDR_W-1:0] head_addr;
    logic [lsu_pkg::WORD_W-1:0] head_data;
    logic [3:0]                 head_strb;
    logic [lsu_pkg::WORD_W-1:0] mem_word;
    logic [lsu_pkg::ADDR_W-1:0] apb_addr;
    logic [lsu_pkg::WORD_W-1:0] fwd_data;
    logic [lsu_pkg::WORD_W-1:0] mem_data;

    // reads go to the load word, writes to the oldest buffer entry
    assign apb_addr    = rd_addr_sel ? {addr_i[lsu_pkg::ADDR_W-1:2], 2'b00} : head_addr;
    assign load_data_o = load_src ? fwd_data : mem_data;

    lsu_ctrl u_ctrl (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .req_store_i   (req_store_i),
        .req_load_i    (req_load_i),
        .fence_i       (fence_i),
        .sb_hit_i      (sb_hit),
        .sb_cover_i    (sb_cover),
        .sb_full_i     (sb_full),
        .sb_empty_i    (sb_empty),
        .apb_done_i    (apb_done),
        .stall_o       (stall_o),
        .sb_alloc_o    (sb_alloc),
        .sb_drain_o    (sb_drain),
        .apb_start_o   (apb_start),
        .apb_write_o   (apb_write),
        .rd_addr_sel_o (rd_addr_sel),
        .load_valid_o  (load_valid_o),
        .load_src_o    (load_src)
    );

    lsu_store_buffer #(
        .SB_DEPTH (SB_DEPTH)
    ) u_store_buffer (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .alloc_i     (sb_alloc),
        .addr_i      (addr_i),
        .wdata_i     (wdata_i),
        .size_i      (size_i),
        .drain_i     (sb_drain),
        .hit_o       (sb_hit),
        .cover_o     (sb_cover),
        .full_o      (sb_full),
        .empty_o     (sb_empty),
        .fwd_word_o  (fwd_word),
        .head_addr_o (head_addr),
        .head_data_o (head_data),
        .head_strb_o (head_strb)
    );

    lsu_apb_master u_apb_master (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .start_i   (apb_start),
        .write_i   (apb_write),
        .addr_i    (apb_addr),
        .wdata_i   (head_data),
        .strb_i    (head_strb),
        .prdata_i  (prdata_i),
        .pready_i  (pready_i),
        .done_o    (apb_done),
        .rdata_o   (mem_word),
        .paddr_o   (paddr_o),
        .psel_o    (psel_o),
        .penable_o (penable_o),
        .pwrite_o  (pwrite_o),
        .pwdata_o  (pwdata_o),
        .pstrb_o   (pstrb_o)
    );

    // forwarded data path
    lsu_load_align u_align_fwd (
        .word_i    (fwd_word),
        .addr_lo_i (addr_i[1:0]),
        .size_i    (size_i),
        .data_o    (fwd_data)
    );

    // memory read data path
    lsu_load_align u_align_mem (
        .word_i    (mem_word),
        .addr_lo_i (addr_i[1:0]),
        .size_i    (size_i),
        .data_o    (mem_data)
    );

endmodule

// ==== sim.f ====
lsu_pkg.sv
lsu_store_buffer.sv
lsu_load_align.sv
lsu_apb_master.sv
lsu_ctrl.sv
lsu_top.sv
tb_lsu_checker.sv
tb_lsu.sv

// ==== tb_lsu.sv ====
`timescale 1ns/10ps

module tb_lsu;

    localparam int SB_DEPTH = 2;
    localparam int TIMEOUT_CYC = 100;
    // 16-word window starting at word 64 of the slave memory
    localparam int WIN_WORD = 64;
    localparam logic [31:0] WIN_BASE = 32'(WIN_WORD * 4);

    logic                 clk_i;
    logic                 arst_n_i;
    logic                 req_store_i;
    logic                 req_load_i;
    logic                 fence_i;
    logic [31:0]          addr_i;
    logic [31:0]          wdata_i;
    lsu_pkg::memop_size_e size_i;
    logic [31:0]          prdata_i;
    logic                 pready_i;
    logic                 stall_o;
    logic                 load_valid_o;
    logic [31:0]          load_data_o;
    logic [31:0]          paddr_o;
    logic                 psel_o;
    logic                 penable_o;
    logic                 pwrite_o;
    logic [31:0]          pwdata_o;
    logic [3:0]           pstrb_o;

    logic [31:0] mem [256];
    logic [31:0] lfsr = 32'h5bfa_f107;
    int          wait_left = 0;
    int          timeouts = 0;

    lsu_top #(
        .SB_DEPTH (SB_DEPTH)
    ) DUT (.*);

    tb_lsu_checker #(
        .SB_DEPTH (SB_DEPTH)
    ) u_check (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .req_store_i  (req_store_i),
        .req_load_i   (req_load_i),
        .addr_i       (addr_i),
        .wdata_i      (wdata_i),
        .size_i       (size_i),
        .stall_i      (stall_o),
        .load_valid_i (load_valid_o),
        .load_data_i  (load_data_o),
        .psel_i       (psel_o),
        .penable_i    (penable_o),
        .pwrite_i     (pwrite_o),
        .paddr_i      (paddr_o),
        .pwdata_i     (pwdata_o),
        .pstrb_i      (pstrb_o),
        .pready_i     (pready_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    // taps 32, 22, 2, 1, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int k = 0; k < n; k++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    // slave picks its wait states in the setup cycle, writes land in the last access cycle
    always @(negedge clk_i) begin
        if (psel_o && !penable_o) begin
            wait_left = int'(rand_bits(2) % 3);
        end
        if (psel_o && penable_o && pready_i && pwrite_o) begin
            for (int b = 0; b < 4; b++) begin
                if (pstrb_o[b]) begin
                    mem[paddr_o[9:2]][8*b +: 8] = pwdata_o[8*b +: 8];
                end
            end
        end
    end

    always @(posedge clk_i) begin
        #10;
        pready_i = 1'b0;
        if (psel_o && penable_o) begin
            if (wait_left == 0) begin
                pready_i = 1'b1;
                prdata_i = mem[paddr_o[9:2]];
            end else begin
                wait_left--;
            end
        end
    end

    task automatic finish_run();
        u_check.print_summary(timeouts);
        if (u_check.error_count() == 0 && timeouts == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    endtask

    task automatic wait_stall_low(input string what);
        int n;
        n = 0;
        @(negedge clk_i);
        while (stall_o && n < TIMEOUT_CYC) begin
            n++;
            @(negedge clk_i);
        end
        if (stall_o) begin
            $display("timeout: stall_o still high after %0d cycles of a %s", n, what);
            timeouts++;
            finish_run();
        end
    endtask

    task automatic wait_load_valid();
        int n;
        n = 0;
        @(negedge clk_i);
        while (!load_valid_o && n < TIMEOUT_CYC) begin
            n++;
            @(negedge clk_i);
        end
        if (!load_valid_o) begin
            $display("timeout: no load_valid_o within %0d cycles for load at %h", n, addr_i);
            timeouts++;
            finish_run();
        end
    endtask

    // every task starts and ends 10 ns after a rising edge
    task automatic do_store(input logic [31:0] a, input lsu_pkg::memop_size_e s,
                            input logic [31:0] d);
        req_store_i = 1'b1;
        addr_i      = a;
        size_i      = s;
        wdata_i     = d;
        wait_stall_low("store");
        @(posedge clk_i);
        #10;
        req_store_i = 1'b0;
    endtask

    task automatic do_load(input logic [31:0] a, input lsu_pkg::memop_size_e s);
        req_load_i = 1'b1;
        addr_i     = a;
        size_i     = s;
        wait_load_valid();
        @(posedge clk_i);
        #10;
        req_load_i = 1'b0;
        @(posedge clk_i);
        #10;
    endtask

    task automatic do_fence();
        fence_i = 1'b1;
        wait_stall_low("fence");
        @(posedge clk_i);
        #10;
        fence_i = 1'b0;
    endtask

    // random naturally aligned access inside the window
    task automatic pick_access(output logic [31:0] a, output lsu_pkg::memop_size_e s);
        logic [1:0] r;
        r = 2'(rand_bits(2));
        s = (r == 2'd0) ? lsu_pkg::BYTE : (r == 2'd1) ? lsu_pkg::HALF : lsu_pkg::WORD;
        a = WIN_BASE + (rand_bits(4) << 2);
        if (s == lsu_pkg::BYTE) begin
            a[1:0] = 2'(rand_bits(2));
        end else if (s == lsu_pkg::HALF) begin
            a[1] = rand_bits(1) != 0;
        end
    endtask

    initial begin
        logic [31:0]          a;
        lsu_pkg::memop_size_e s;
        arst_n_i    = 1'b0;
        req_store_i = 1'b0;
        req_load_i  = 1'b0;
        fence_i     = 1'b0;
        addr_i      = '0;
        wdata_i     = '0;
        size_i      = lsu_pkg::WORD;
        prdata_i    = '0;
        pready_i    = 1'b0;
        for (int i = 0; i < 256; i++) begin
            mem[i] = 32'h9e37_79b9 * (i + 1);
            u_check.seed_word(i, mem[i]);
        end
        repeat (5) @(posedge clk_i);
        #10;
        arst_n_i = 1'b1;

        // store then load back the same bytes
        repeat (8) begin
            pick_access(a, s);
            do_store(a, s, rand_bits(32));
            do_load(a, s);
        end

        // four byte stores merge into a single word write
        do_fence();
        for (int b = 0; b < 4; b++) begin
            do_store(WIN_BASE + 32'h24 + 32'(b), lsu_pkg::BYTE, rand_bits(8));
        end
        do_load(WIN_BASE + 32'h24, lsu_pkg::WORD);
        do_fence();

        // more distinct words than entries
        for (int i = 0; i < SB_DEPTH + 2; i++) begin
            do_store(WIN_BASE + 32'h30 + 32'(4 * i), lsu_pkg::WORD, rand_bits(32));
        end
        do_fence();

        // one buffered byte, the rest of the word from memory
        do_store(WIN_BASE + 32'h09, lsu_pkg::BYTE, rand_bits(8));
        do_load(WIN_BASE + 32'h08, lsu_pkg::WORD);

        repeat (300) begin
            pick_access(a, s);
            if (rand_bits(1) != 0) begin
                do_store(a, s, rand_bits(32));
            end else begin
                do_load(a, s);
            end
        end
        do_fence();

        for (int w = 0; w < 16; w++) begin
            u_check.compare_word(WIN_WORD + w, mem[WIN_WORD + w]);
        end
        u_check.check_empty();
        finish_run();
    end

endmodule

// ==== tb_lsu_checker.sv ====
`timescale 1ns/10ps

module tb_lsu_checker #(
    parameter int SB_DEPTH = 2
) (
    input logic                 clk_i,
    input logic                 arst_n_i,
    input logic                 req_store_i,
    input logic                 req_load_i,
    input logic [31:0]          addr_i,
    input logic [31:0]          wdata_i,
    input lsu_pkg::memop_size_e size_i,
    input logic                 stall_i,
    input logic                 load_valid_i,
    input logic [31:0]          load_data_i,
    input logic                 psel_i,
    input logic                 penable_i,
    input logic                 pwrite_i,
    input logic [31:0]          paddr_i,
    input logic [31:0]          pwdata_i,
    input logic [3:0]           pstrb_i,
    input logic                 pready_i
);

    // byte image of the 256-word slave memory as the core sees it
    logic [7:0]  shadow [1024];
    // words expected in the store buffer, oldest first
    logic [29:0] sb_words [$];
    logic [3:0]  sb_masks [$];

    int   load_errors = 0;
    int   bus_errors = 0;
    int   mem_errors = 0;
    logic busy = 1'b0;
    logic expect_fwd = 1'b0;
    logic read_seen = 1'b0;
    logic end_prev = 1'b0;
    int   lat = 0;

    function automatic int size_bytes(input lsu_pkg::memop_size_e size);
        case (size)
            lsu_pkg::BYTE: return 1;
            lsu_pkg::HALF: return 2;
            default:       return 4;
        endcase
    endfunction

    // lowest byte of a naturally aligned access
    function automatic int first_byte(input logic [31:0] addr, input lsu_pkg::memop_size_e size);
        return int'(addr[9:0]) & ~(size_bytes(size) - 1);
    endfunction

    // expected load value, the addressed bytes zero-extended
    function automatic logic [31:0] ref_load(input logic [31:0] addr,
                                             input lsu_pkg::memop_size_e size);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < size_bytes(size); k++) begin
            v[8*k +: 8] = shadow[first_byte(addr, size) + k];
        end
        return v;
    endfunction

    function automatic logic [3:0] lane_mask(input logic [31:0] addr,
                                             input lsu_pkg::memop_size_e size);
        logic [3:0] m;
        m = '0;
        for (int k = 0; k < size_bytes(size); k++) begin
            m[(first_byte(addr, size) + k) % 4] = 1'b1;
        end
        return m;
    endfunction

    function automatic int find_word(input logic [29:0] w);
        for (int i = 0; i < sb_words.size(); i++) begin
            if (sb_words[i] == w) begin
                return i;
            end
        end
        return -1;
    endfunction

    function automatic logic covers(input logic [31:0] addr, input lsu_pkg::memop_size_e size);
        int idx;
        idx = find_word(addr[31:2]);
        if (idx < 0) begin
            return 1'b0;
        end
        return (sb_masks[idx] & lane_mask(addr, size)) == lane_mask(addr, size);
    endfunction

    task automatic record_store();
        int idx;
        idx = find_word(addr_i[31:2]);
        if (idx < 0 && sb_words.size() >= SB_DEPTH) begin
            bus_errors++;
            $display("store to new word %h accepted while the buffer was full", addr_i);
        end
        for (int k = 0; k < size_bytes(size_i); k++) begin
            shadow[first_byte(addr_i, size_i) + k] = wdata_i[8*k +: 8];
        end
        if (idx < 0) begin
            sb_words.push_back(addr_i[31:2]);
            sb_masks.push_back(lane_mask(addr_i, size_i));
        end else begin
            sb_masks[idx] = sb_masks[idx] | lane_mask(addr_i, size_i);
        end
    endtask

    // drains leave in store order, merged data under the merged mask
    task automatic check_drain();
        logic [31:0] exp_w;
        logic [31:0] keep;
        if (sb_words.size() == 0) begin
            bus_errors++;
            $display("APB write to %h while no store was waiting", paddr_i);
        end else begin
            exp_w = ref_load({sb_words[0], 2'b00}, lsu_pkg::WORD);
            keep  = {{8{sb_masks[0][3]}}, {8{sb_masks[0][2]}},
                     {8{sb_masks[0][1]}}, {8{sb_masks[0][0]}}};
            if (paddr_i != {sb_words[0], 2'b00}) begin
                bus_errors++;
                $display("FAIL paddr_o: expected %h, got %h", {sb_words[0], 2'b00}, paddr_i);
            end
            if (pstrb_i != sb_masks[0]) begin
                bus_errors++;
                $display("FAIL pstrb_o: expected %h, got %h", sb_masks[0], pstrb_i);
            end
            if ((pwdata_i & keep) != (exp_w & keep)) begin
                bus_errors++;
                $display("FAIL pwdata_o: expected %h, got %h", exp_w & keep, pwdata_i & keep);
            end
            sb_words.pop_front();
            sb_masks.pop_front();
        end
    endtask

    // a read goes to the word of the pending load with no byte strobes
    task automatic check_read();
        read_seen = 1'b1;
        if (find_word(addr_i[31:2]) >= 0) begin
            bus_errors++;
            $display("memory read of %h while its word is still buffered", addr_i);
        end
        if (paddr_i !== {addr_i[31:2], 2'b00}) begin
            bus_errors++;
            $display("FAIL paddr_o: expected %h, got %h", {addr_i[31:2], 2'b00}, paddr_i);
        end
        if (pstrb_i !== 4'h0) begin
            bus_errors++;
            $display("FAIL pstrb_o: expected %h, got %h", 4'h0, pstrb_i);
        end
    endtask

    task automatic check_load();
        logic [31:0] exp_d;
        if (!busy) begin
            load_errors++;
            $display("load_valid_o went high with no load pending");
        end else begin
            exp_d = ref_load(addr_i, size_i);
            if (load_data_i !== exp_d) begin
                load_errors++;
                $display("FAIL load_data_o: expected %h, got %h (addr %h)",
                         exp_d, load_data_i, addr_i);
            end
            if (expect_fwd && (lat != 1 || read_seen)) begin
                load_errors++;
                $display("covered load at %h took %0d cycles instead of one", addr_i, lat);
            end
            if (!read_seen && !covers(addr_i, size_i)) begin
                load_errors++;
                $display("load at %h returned without a memory read", addr_i);
            end
            busy = 1'b0;
        end
    endtask

    // everything is sampled mid-cycle, away from the edges
    always @(negedge clk_i) begin
        if (arst_n_i) begin
            if (req_store_i && !stall_i) begin
                record_store();
            end
            if (psel_i && penable_i && pready_i && pwrite_i) begin
                check_drain();
            end
            if (req_load_i && !busy) begin
                busy      = 1'b1;
                lat       = 0;
                read_seen = 1'b0;
                // controller idle and the buffer holds every byte
                expect_fwd = !psel_i && !end_prev && covers(addr_i, size_i);
            end else if (busy) begin
                lat++;
            end
            if (psel_i && !penable_i && !pwrite_i) begin
                check_read();
            end
            if (load_valid_i) begin
                check_load();
            end
            end_prev = psel_i && penable_i && pready_i;
        end
    end

    task automatic seed_word(input int w, input logic [31:0] v);
        for (int k = 0; k < 4; k++) begin
            shadow[4*w + k] = v[8*k +: 8];
        end
    endtask

    task automatic compare_word(input int w, input logic [31:0] v);
        logic [31:0] exp_w;
        exp_w = ref_load(32'(4 * w), lsu_pkg::WORD);
        if (v !== exp_w) begin
            mem_errors++;
            $display("FAIL mem[%0d]: expected %h, got %h", w, exp_w, v);
        end
    endtask

    task automatic check_empty();
        if (sb_words.size() != 0) begin
            bus_errors++;
            $display("%0d stores never reached memory after the fence", sb_words.size());
        end
    endtask

    function automatic int error_count();
        return load_errors + bus_errors + mem_errors;
    endfunction

    task automatic print_summary(input int timeouts);
        $display("errors: load %0d, bus %0d, memory %0d, timeout %0d",
                 load_errors, bus_errors, mem_errors, timeouts);
    endtask

endmodule
